// File: ram_pkg.sv
/* Shared sizes and the memory line type of the dual-width AXI4-lite RAM */

package ram_pkg;

    ////////////////////////////////////////
    // Bus and memory geometry
    ////////////////////////////////////////

    // Byte address width seen on both ports
    localparam int ADDR_W = 10;

    // One memory line holds the full width of the wide port
    localparam int LINE_W = 64;

    // Data widths of the two slave ports
    localparam int NARROW_W = 32;
    localparam int WIDE_W = LINE_W;

    // Lines needed to cover the whole byte address space
    localparam int LINE_NUM = (2 ** ADDR_W) / (LINE_W / 8);

    // Requests buffered per channel before ready drops
    localparam int OSTD_DEPTH = 4;

    ////////////////////////////////////////
    // Memory line
    ////////////////////////////////////////

    // The wide port sees the whole line, the narrow port sees two words
    // and word 1 is the upper half
    typedef union packed {
        logic [LINE_W-1:0] line;
        logic [1:0][NARROW_W-1:0] word;
    } ram_line_t;

endpackage

// File: req_fifo.sv
/* Request FIFO, buffers one AXI4-lite request channel of a port */

module req_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             push,
    input  logic [WIDTH-1:0] data_in,
    output logic             full,
    input  logic             pull,
    output logic [WIDTH-1:0] data_out,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] store [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pull) begin
                count <= count + 1'b1;
            end else if (pull && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Payload storage
    always_ff @(posedge aclk) begin
        if (push) begin
            store[wr_ptr] <= data_in;
        end
    end

    assign data_out = store[rd_ptr];
    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // The owner gates push with full and pull with its own response state
    assert property (@(posedge aclk) disable iff (!aresetn) !(push && full))
        else $error("req_fifo: push while full");

    assert property (@(posedge aclk) disable iff (!aresetn) !(pull && empty))
        else $error("req_fifo: pull while empty");

endmodule

// File: lane_ram.sv
/* Shared line RAM, the narrow port selects a word lane and the wide port
   takes the whole line, both with byte strobes */

module lane_ram (
    input  logic                           aclk,
    // Narrow port
    input  logic                           p1_wr_en,
    input  logic [ram_pkg::ADDR_W-1:0]     p1_wr_addr,
    input  logic [ram_pkg::NARROW_W-1:0]   p1_wr_data,
    input  logic [ram_pkg::NARROW_W/8-1:0] p1_wr_strb,
    input  logic [ram_pkg::ADDR_W-1:0]     p1_rd_addr,
    output logic [ram_pkg::NARROW_W-1:0]   p1_rd_data,
    // Wide port
    input  logic                           p2_wr_en,
    input  logic [ram_pkg::ADDR_W-1:0]     p2_wr_addr,
    input  logic [ram_pkg::WIDE_W-1:0]     p2_wr_data,
    input  logic [ram_pkg::WIDE_W/8-1:0]   p2_wr_strb,
    input  logic [ram_pkg::ADDR_W-1:0]     p2_rd_addr,
    output logic [ram_pkg::WIDE_W-1:0]     p2_rd_data
);

    // Byte offset bits inside one line
    localparam int OFS_W = $clog2(ram_pkg::LINE_W / 8);
    localparam int IDX_W = ram_pkg::ADDR_W - OFS_W;

    ram_pkg::ram_line_t mem [ram_pkg::LINE_NUM];

    logic [IDX_W-1:0] p1_wr_idx;
    logic [IDX_W-1:0] p1_rd_idx;
    logic [IDX_W-1:0] p2_wr_idx;
    logic [IDX_W-1:0] p2_rd_idx;
    logic             p1_wr_lane;
    logic             p1_rd_lane;

    assign p1_wr_idx = p1_wr_addr[ram_pkg::ADDR_W-1:OFS_W];
    assign p1_rd_idx = p1_rd_addr[ram_pkg::ADDR_W-1:OFS_W];
    assign p2_wr_idx = p2_wr_addr[ram_pkg::ADDR_W-1:OFS_W];
    assign p2_rd_idx = p2_rd_addr[ram_pkg::ADDR_W-1:OFS_W];

    // Address bit 2 picks the upper word for the narrow port
    assign p1_wr_lane = p1_wr_addr[OFS_W-1];
    assign p1_rd_lane = p1_rd_addr[OFS_W-1];

    ////////////////////////////////////////
    // Byte-strobe writes
    ////////////////////////////////////////

    // Port 2 is written last, so its bytes win a same-cycle collision
    always_ff @(posedge aclk) begin
        if (p1_wr_en) begin
            for (int i = 0; i < ram_pkg::NARROW_W / 8; i++) begin
                if (p1_wr_strb[i]) begin
                    mem[p1_wr_idx].word[p1_wr_lane][8*i+:8] <= p1_wr_data[8*i+:8];
                end
            end
        end
        if (p2_wr_en) begin
            for (int i = 0; i < ram_pkg::WIDE_W / 8; i++) begin
                if (p2_wr_strb[i]) begin
                    mem[p2_wr_idx].line[8*i+:8] <= p2_wr_data[8*i+:8];
                end
            end
        end
    end

    // Reads are combinational from the engines' head addresses
    assign p1_rd_data = mem[p1_rd_idx].word[p1_rd_lane];
    assign p2_rd_data = mem[p2_rd_idx].line;

    // Write enables come from reset engine state, so they are never unknown
    assert property (@(posedge aclk) !$isunknown({p1_wr_en, p2_wr_en}))
        else $error("lane_ram: unknown write enable");

endmodule

// File: port_engine.sv
/* AXI4-lite port engine, buffers requests, sequences in-order reads and
   writes against the line RAM and holds the rvalid and bvalid flags */

module port_engine #(
    parameter int DATA_W = 32,
    parameter int DEPTH = 4
) (
    input  logic                       aclk,
    input  logic                       aresetn,
    // Write address and data channels
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [ram_pkg::ADDR_W-1:0] awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [DATA_W-1:0]          wdata,
    input  logic [DATA_W/8-1:0]        wstrb,
    // Write response channel
    output logic                       bvalid,
    input  logic                       bready,
    // Read channels
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [ram_pkg::ADDR_W-1:0] araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output logic [DATA_W-1:0]          rdata,
    // Line RAM side
    output logic                       wr_en,
    output logic [ram_pkg::ADDR_W-1:0] wr_addr,
    output logic [DATA_W-1:0]          wr_data,
    output logic [DATA_W/8-1:0]        wr_strb,
    output logic [ram_pkg::ADDR_W-1:0] rd_addr,
    input  logic [DATA_W-1:0]          rd_data
);

    localparam int STRB_W = DATA_W / 8;
    // One slot more than DEPTH, the head stays in the FIFO while in flight
    localparam int FIFO_DEPTH = DEPTH + 1;

    logic                       aw_push;
    logic                       aw_full;
    logic                       aw_empty;
    logic                       w_push;
    logic                       w_full;
    logic                       w_empty;
    logic [DATA_W+STRB_W-1:0]   w_head;
    logic                       ar_push;
    logic                       ar_full;
    logic                       ar_empty;
    logic                       ar_pull;
    logic                       wr_go;

    ////////////////////////////////////////
    // Request FIFOs
    ////////////////////////////////////////

    assign awready = !aw_full;
    assign wready = !w_full;
    assign arready = !ar_full;

    assign aw_push = awvalid && !aw_full;
    assign w_push = wvalid && !w_full;
    assign ar_push = arvalid && !ar_full;

    req_fifo #(.WIDTH(ram_pkg::ADDR_W), .DEPTH(FIFO_DEPTH)) aw_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (aw_push),
        .data_in  (awaddr),
        .full     (aw_full),
        .pull     (wr_go),
        .data_out (wr_addr),
        .empty    (aw_empty)
    );

    req_fifo #(.WIDTH(DATA_W + STRB_W), .DEPTH(FIFO_DEPTH)) w_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (w_push),
        .data_in  ({wstrb, wdata}),
        .full     (w_full),
        .pull     (wr_go),
        .data_out (w_head),
        .empty    (w_empty)
    );

    req_fifo #(.WIDTH(ram_pkg::ADDR_W), .DEPTH(FIFO_DEPTH)) ar_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (ar_push),
        .data_in  (araddr),
        .full     (ar_full),
        .pull     (ar_pull),
        .data_out (rd_addr),
        .empty    (ar_empty)
    );

    ////////////////////////////////////////
    // Write sequencing
    ////////////////////////////////////////

    // A write goes out once both heads are there and no response is pending
    assign wr_go = !bvalid && !aw_empty && !w_empty;
    assign wr_en = wr_go;
    assign wr_data = w_head[DATA_W-1:0];
    assign wr_strb = w_head[DATA_W+:STRB_W];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            bvalid <= 1'b0;
        end else if (bvalid) begin
            if (bready) begin
                bvalid <= 1'b0;
            end
        end else if (wr_go) begin
            bvalid <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Read sequencing
    ////////////////////////////////////////

    // The RAM reads the head address, so rdata holds while the head stays
    assign ar_pull = rvalid && rready;
    assign rdata = rd_data;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rvalid <= 1'b0;
        end else if (rvalid) begin
            if (rready) begin
                rvalid <= 1'b0;
            end
        end else if (!ar_empty) begin
            rvalid <= 1'b1;
        end
    end

    // Responses and their read data are held until the manager takes them
    assert property (@(posedge aclk) disable iff (!aresetn)
                     rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("port_engine: rvalid or rdata changed without rready");

    assert property (@(posedge aclk) disable iff (!aresetn) bvalid && !bready |=> bvalid)
        else $error("port_engine: bvalid dropped without bready");

endmodule

// File: axi_ram_top.sv
/* Dual-width AXI4-lite RAM, a 32-bit and a 64-bit slave port on one memory */

module axi_ram_top #(
    parameter int OSTD_DEPTH = ram_pkg::OSTD_DEPTH
) (
    input  logic                           aclk,
    input  logic                           aresetn,
    // Port 1, narrow
    input  logic                           p1_awvalid,
    output logic                           p1_awready,
    input  logic [ram_pkg::ADDR_W-1:0]     p1_awaddr,
    input  logic                           p1_wvalid,
    output logic                           p1_wready,
    input  logic [ram_pkg::NARROW_W-1:0]   p1_wdata,
    input  logic [ram_pkg::NARROW_W/8-1:0] p1_wstrb,
    output logic                           p1_bvalid,
    input  logic                           p1_bready,
    input  logic                           p1_arvalid,
    output logic                           p1_arready,
    input  logic [ram_pkg::ADDR_W-1:0]     p1_araddr,
    output logic                           p1_rvalid,
    input  logic                           p1_rready,
    output logic [ram_pkg::NARROW_W-1:0]   p1_rdata,
    // Port 2, wide
    input  logic                           p2_awvalid,
    output logic                           p2_awready,
    input  logic [ram_pkg::ADDR_W-1:0]     p2_awaddr,
    input  logic                           p2_wvalid,
    output logic                           p2_wready,
    input  logic [ram_pkg::WIDE_W-1:0]     p2_wdata,
    input  logic [ram_pkg::WIDE_W/8-1:0]   p2_wstrb,
    output logic                           p2_bvalid,
    input  logic                           p2_bready,
    input  logic                           p2_arvalid,
    output logic                           p2_arready,
    input  logic [ram_pkg::ADDR_W-1:0]     p2_araddr,
    output logic                           p2_rvalid,
    input  logic                           p2_rready,
    output logic [ram_pkg::WIDE_W-1:0]     p2_rdata
);

    ////////////////////////////////////////
    // Engine to RAM wiring
    ////////////////////////////////////////

    logic                           p1_wr_en;
    logic [ram_pkg::ADDR_W-1:0]     p1_wr_addr;
    logic [ram_pkg::NARROW_W-1:0]   p1_wr_data;
    logic [ram_pkg::NARROW_W/8-1:0] p1_wr_strb;
    logic [ram_pkg::ADDR_W-1:0]     p1_rd_addr;
    logic [ram_pkg::NARROW_W-1:0]   p1_rd_data;

    logic                           p2_wr_en;
    logic [ram_pkg::ADDR_W-1:0]     p2_wr_addr;
    logic [ram_pkg::WIDE_W-1:0]     p2_wr_data;
    logic [ram_pkg::WIDE_W/8-1:0]   p2_wr_strb;
    logic [ram_pkg::ADDR_W-1:0]     p2_rd_addr;
    logic [ram_pkg::WIDE_W-1:0]     p2_rd_data;

    port_engine #(.DATA_W(ram_pkg::NARROW_W), .DEPTH(OSTD_DEPTH)) port1_engine (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awvalid (p1_awvalid),
        .awready (p1_awready),
        .awaddr  (p1_awaddr),
        .wvalid  (p1_wvalid),
        .wready  (p1_wready),
        .wdata   (p1_wdata),
        .wstrb   (p1_wstrb),
        .bvalid  (p1_bvalid),
        .bready  (p1_bready),
        .arvalid (p1_arvalid),
        .arready (p1_arready),
        .araddr  (p1_araddr),
        .rvalid  (p1_rvalid),
        .rready  (p1_rready),
        .rdata   (p1_rdata),
        .wr_en   (p1_wr_en),
        .wr_addr (p1_wr_addr),
        .wr_data (p1_wr_data),
        .wr_strb (p1_wr_strb),
        .rd_addr (p1_rd_addr),
        .rd_data (p1_rd_data)
    );

    port_engine #(.DATA_W(ram_pkg::WIDE_W), .DEPTH(OSTD_DEPTH)) port2_engine (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awvalid (p2_awvalid),
        .awready (p2_awready),
        .awaddr  (p2_awaddr),
        .wvalid  (p2_wvalid),
        .wready  (p2_wready),
        .wdata   (p2_wdata),
        .wstrb   (p2_wstrb),
        .bvalid  (p2_bvalid),
        .bready  (p2_bready),
        .arvalid (p2_arvalid),
        .arready (p2_arready),
        .araddr  (p2_araddr),
        .rvalid  (p2_rvalid),
        .rready  (p2_rready),
        .rdata   (p2_rdata),
        .wr_en   (p2_wr_en),
        .wr_addr (p2_wr_addr),
        .wr_data (p2_wr_data),
        .wr_strb (p2_wr_strb),
        .rd_addr (p2_rd_addr),
        .rd_data (p2_rd_data)
    );

    lane_ram ram (
        .aclk       (aclk),
        .p1_wr_en   (p1_wr_en),
        .p1_wr_addr (p1_wr_addr),
        .p1_wr_data (p1_wr_data),
        .p1_wr_strb (p1_wr_strb),
        .p1_rd_addr (p1_rd_addr),
        .p1_rd_data (p1_rd_data),
        .p2_wr_en   (p2_wr_en),
        .p2_wr_addr (p2_wr_addr),
        .p2_wr_data (p2_wr_data),
        .p2_wr_strb (p2_wr_strb),
        .p2_rd_addr (p2_rd_addr),
        .p2_rd_data (p2_rd_data)
    );

endmodule

// File: tb_axi_ram.sv
/* Testbench for the dual-width AXI4-lite RAM, directed and random traffic
   checked against a byte model of the memory */

module tb_axi_ram;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW = ram_pkg::ADDR_W;
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RANDOM_OPS = 100;

    logic aclk;
    logic aresetn;

    // Index 1 is the narrow port, index 2 the wide port
    logic [2:1]         awvalid;
    logic [2:1][AW-1:0] awaddr;
    logic [2:1]         wvalid;
    logic [2:1][63:0]   wdata;
    logic [2:1][7:0]    wstrb;
    logic [2:1]         bready;
    logic [2:1]         arvalid;
    logic [2:1][AW-1:0] araddr;
    logic [2:1]         rready;
    wire  [2:1]         awready;
    wire  [2:1]         wready;
    wire  [2:1]         bvalid;
    wire  [2:1]         arready;
    wire  [2:1]         rvalid;
    wire  [31:0]        p1_rdata;
    wire  [63:0]        p2_rdata;

    logic [7:0]  ref_mem [2**AW];
    logic [63:0] exp_q1 [$];
    logic [63:0] exp_q2 [$];
    logic [2:1]  bvalid_seen;
    int          writes_done [2:1];
    int          b_count [2:1];
    int          data_errors;
    int          proto_errors;
    int          cycles;

    axi_ram_top axi_ram_top_inst (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .p1_awvalid (awvalid[1]),
        .p1_awready (awready[1]),
        .p1_awaddr  (awaddr[1]),
        .p1_wvalid  (wvalid[1]),
        .p1_wready  (wready[1]),
        .p1_wdata   (wdata[1][31:0]),
        .p1_wstrb   (wstrb[1][3:0]),
        .p1_bvalid  (bvalid[1]),
        .p1_bready  (bready[1]),
        .p1_arvalid (arvalid[1]),
        .p1_arready (arready[1]),
        .p1_araddr  (araddr[1]),
        .p1_rvalid  (rvalid[1]),
        .p1_rready  (rready[1]),
        .p1_rdata   (p1_rdata),
        .p2_awvalid (awvalid[2]),
        .p2_awready (awready[2]),
        .p2_awaddr  (awaddr[2]),
        .p2_wvalid  (wvalid[2]),
        .p2_wready  (wready[2]),
        .p2_wdata   (wdata[2]),
        .p2_wstrb   (wstrb[2]),
        .p2_bvalid  (bvalid[2]),
        .p2_bready  (bready[2]),
        .p2_arvalid (arvalid[2]),
        .p2_arready (arready[2]),
        .p2_araddr  (araddr[2]),
        .p2_rvalid  (rvalid[2]),
        .p2_rready  (rready[2]),
        .p2_rdata   (p2_rdata)
    );

    always #5 aclk = ~aclk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Port 1 sees the 32-bit word picked by address bit 2, port 2 the whole line
    function automatic logic [63:0] ref_read(input int port, input logic [AW-1:0] addr);
        logic [63:0] value;
        int nbytes;
        int base;
        value = '0;
        nbytes = (port == 1) ? 4 : 8;
        base = int'(addr) / nbytes * nbytes;
        for (int i = 0; i < nbytes; i++) begin
            value[8*i+:8] = ref_mem[base + i];
        end
        return value;
    endfunction

    function automatic void apply_write(input int port, input logic [AW-1:0] addr,
                                        input logic [63:0] data, input logic [7:0] strb);
        int nbytes;
        int base;
        nbytes = (port == 1) ? 4 : 8;
        base = int'(addr) / nbytes * nbytes;
        for (int i = 0; i < nbytes; i++) begin
            if (strb[i]) begin
                ref_mem[base + i] = data[8*i+:8];
            end
        end
    endfunction

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got, input bit data_check);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s expected %h, actual %h", $time, name, exp, got);
            if (data_check) begin
                data_errors++;
            end else begin
                proto_errors++;
            end
        end
    endtask

    task automatic compare_read(input int port, input logic [63:0] got);
        int pending;
        logic [63:0] exp;
        pending = (port == 1) ? exp_q1.size() : exp_q2.size();
        assert (pending > 0) else begin
            $display("Port %0d returned read data with no read outstanding at %0t ns",
                     port, $time);
            proto_errors++;
        end
        if (pending > 0) begin
            if (port == 1) begin
                exp = exp_q1.pop_front();
            end else begin
                exp = exp_q2.pop_front();
            end
            check_value($sformatf("p%0d_rdata", port), exp, got, 1'b1);
        end
    endtask

    // Read data is taken at the handshake edge
    // Every rise of bvalid counts as one write response
    always @(posedge aclk) begin
        if (aresetn) begin
            if (rvalid[1] && rready[1]) begin
                compare_read(1, {32'h0, p1_rdata});
            end
            if (rvalid[2] && rready[2]) begin
                compare_read(2, p2_rdata);
            end
            for (int p = 1; p <= 2; p++) begin
                if (bvalid[p] && !bvalid_seen[p]) begin
                    b_count[p]++;
                end
            end
            bvalid_seen = bvalid;
        end else begin
            bvalid_seen = '0;
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic init_inputs();
        aclk = 1'b0;
        aresetn = 1'b1;
        awvalid = '0;
        awaddr = '0;
        wvalid = '0;
        wdata = '0;
        wstrb = '0;
        bready = '0;
        arvalid = '0;
        araddr = '0;
        rready = '0;
    endtask

    // Holds bready low for stall cycles once bvalid is up
    task automatic write_data(input int port, input logic [AW-1:0] addr,
                              input logic [63:0] data, input logic [7:0] strb, input int stall);
        bit aw_take;
        bit w_take;
        @(negedge aclk);
        awaddr[port] = addr;
        wdata[port] = data;
        wstrb[port] = strb;
        awvalid[port] = 1'b1;
        wvalid[port] = 1'b1;
        while (awvalid[port] || wvalid[port]) begin
            aw_take = awvalid[port] && awready[port];
            w_take = wvalid[port] && wready[port];
            @(negedge aclk);
            if (aw_take) begin
                awvalid[port] = 1'b0;
            end
            if (w_take) begin
                wvalid[port] = 1'b0;
            end
        end
        while (!bvalid[port]) begin
            @(negedge aclk);
        end
        repeat (stall) begin
            @(negedge aclk);
            check_value($sformatf("p%0d_bvalid", port), 64'(1), 64'(bvalid[port]), 1'b0);
        end
        bready[port] = 1'b1;
        @(negedge aclk);
        bready[port] = 1'b0;
        check_value($sformatf("p%0d_bvalid", port), 64'(0), 64'(bvalid[port]), 1'b0);
        apply_write(port, addr, data, strb);
        writes_done[port]++;
    endtask

    task automatic read_back(input int port, input logic [AW-1:0] addr, input int stall);
        bit take;
        @(negedge aclk);
        if (port == 1) begin
            exp_q1.push_back(ref_read(1, addr));
        end else begin
            exp_q2.push_back(ref_read(2, addr));
        end
        araddr[port] = addr;
        arvalid[port] = 1'b1;
        take = 1'b0;
        while (!take) begin
            take = arready[port];
            @(negedge aclk);
        end
        arvalid[port] = 1'b0;
        while (!rvalid[port]) begin
            @(negedge aclk);
        end
        repeat (stall) begin
            @(negedge aclk);
        end
        rready[port] = 1'b1;
        @(negedge aclk);
        rready[port] = 1'b0;
    endtask

    // Fills port 1 reads with rready low until arready drops
    task automatic stall_reads();
        int accepted;
        logic [AW-1:0] addr;
        accepted = 0;
        @(negedge aclk);
        while (arready[1] && accepted < 16) begin
            addr = AW'(10'h40 + (accepted % 2) * 4 + (accepted / 2 % 2) * 64);
            exp_q1.push_back(ref_read(1, addr));
            araddr[1] = addr;
            arvalid[1] = 1'b1;
            accepted++;
            @(negedge aclk);
        end
        arvalid[1] = 1'b0;
        assert (!arready[1]) else begin
            $display("Port 1 arready never fell with rready held low");
            proto_errors++;
        end
        assert (accepted >= ram_pkg::OSTD_DEPTH + 1) else begin
            $display("Port 1 arready fell after only %0d accepted reads", accepted);
            proto_errors++;
        end
        repeat (3) @(negedge aclk);
        rready[1] = 1'b1;
        while (exp_q1.size() != 0) begin
            @(negedge aclk);
        end
        rready[1] = 1'b0;
    endtask

    task automatic random_traffic(input int port, input int ops);
        int first_line;
        logic [AW-1:0] addr;
        // Each port owns eight lines, so concurrent writes never meet
        first_line = (port == 1) ? 16 : 24;
        for (int line = first_line; line < first_line + 8; line++) begin
            if (port == 1) begin
                write_data(1, AW'(line * 8), {32'h0, $urandom}, 8'h0f, 0);
                write_data(1, AW'(line * 8 + 4), {32'h0, $urandom}, 8'h0f, 0);
            end else begin
                write_data(2, AW'(line * 8), {$urandom, $urandom}, 8'hff, 0);
            end
        end
        repeat (ops) begin
            addr = AW'((first_line + int'($urandom % 8)) * 8);
            if (port == 1) begin
                addr[2] = 1'($urandom % 2);
            end
            if ($urandom % 2) begin
                write_data(port, addr, {$urandom, $urandom}, 8'($urandom), int'($urandom % 4));
            end else begin
                read_back(port, addr, int'($urandom % 4));
            end
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'hdec7db1d));
        data_errors = 0;
        proto_errors = 0;
        writes_done = '{0, 0};
        b_count = '{0, 0};
        init_inputs();
        #1;
        aresetn = 1'b0;
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);

        check_value("rvalid", 64'(0), 64'(rvalid), 1'b0);
        check_value("bvalid", 64'(0), 64'(bvalid), 1'b0);
        check_value("awready", 64'(3), 64'(awready), 1'b0);
        check_value("wready", 64'(3), 64'(wready), 1'b0);
        check_value("arready", 64'(3), 64'(arready), 1'b0);

        // Narrow writes to both halves of one line
        write_data(1, AW'(10'h40), 64'h0000_0000_1122_3344, 8'h0f, 3);
        write_data(1, AW'(10'h44), 64'h0000_0000_5566_7788, 8'h0f, 0);
        read_back(1, AW'(10'h40), 0);
        read_back(1, AW'(10'h44), 2);

        // Wide line seen through the narrow lanes, then a partial narrow merge
        write_data(2, AW'(10'h80), 64'h89ab_cdef_0123_4567, 8'hff, 1);
        read_back(1, AW'(10'h80), 0);
        read_back(1, AW'(10'h84), 0);
        write_data(1, AW'(10'h84), 64'h0000_0000_a5a5_5a5a, 8'h05, 2);
        read_back(2, AW'(10'h80), 1);

        stall_reads();

        fork
            random_traffic(1, RANDOM_OPS);
            random_traffic(2, RANDOM_OPS);
        join

        repeat (4) @(negedge aclk);
        assert (exp_q1.size() == 0 && exp_q2.size() == 0) else begin
            $display("Reads still waiting for data at the end of the run");
            proto_errors++;
        end
        for (int p = 1; p <= 2; p++) begin
            assert (b_count[p] == writes_done[p]) else begin
                $display("Port %0d gave %0d write responses for %0d writes",
                         p, b_count[p], writes_done[p]);
                proto_errors++;
            end
        end

        $display("Errors: %0d data mismatches, %0d protocol errors", data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d data mismatches, %0d protocol errors", data_errors, proto_errors);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: sim.f
ram_pkg.sv
req_fifo.sv
lane_ram.sv
port_engine.sv
axi_ram_top.sv
tb_axi_ram.sv
